/* proc_defines.svh */
// Processor core shared macros
// Word width, register file size, instruction field positions,
// opcode and ALU operation encodings of the supported subset
`ifndef PROC_DEFINES_SVH
`define PROC_DEFINES_SVH

`define PROC_XLEN       32
`define PROC_REGS       32
`define PROC_RA         31                // jal link register

`define PROC_OP_F       31:27
`define PROC_RD_F       26:22
`define PROC_RS_F       21:17
`define PROC_RT_F       16:12
`define PROC_SHAMT_F    11:7
`define PROC_ALU_F      6:2
`define PROC_IMM_F      16:0
`define PROC_IMM_W      17
`define PROC_TGT_F      26:0
`define PROC_TGT_W      27

`define PROC_OP_RTYPE   5'b00000
`define PROC_OP_J       5'b00001
`define PROC_OP_BNE     5'b00010
`define PROC_OP_JAL     5'b00011
`define PROC_OP_JR      5'b00100
`define PROC_OP_ADDI    5'b00101
`define PROC_OP_BLT     5'b00110
`define PROC_OP_SW      5'b00111
`define PROC_OP_LW      5'b01000

`define PROC_ALU_ADD    5'd0
`define PROC_ALU_SUB    5'd1
`define PROC_ALU_AND    5'd2
`define PROC_ALU_OR     5'd3
`define PROC_ALU_SLL    5'd4
`define PROC_ALU_SRA    5'd5

`endif

/* proc_pkg.sv */
// Processor core package
// Vector types for the quantities that travel between the pipeline
// stages, shared by the RTL and the testbench
`include "proc_defines.svh"

package proc_pkg;

    // Data or address word
    typedef logic [`PROC_XLEN-1:0] word_t;

    // Register file index
    typedef logic [$clog2(`PROC_REGS)-1:0] reg_idx_t;

    // Instruction opcode field
    typedef logic [4:0] opcode_t;

    // ALU operation select for R-type
    typedef logic [4:0] alu_op_t;

    // Shift amount field
    typedef logic [4:0] shamt_t;

endpackage

/* fetch_unit.sv */
// Fetch stage
// Holds the program counter and the fetch/decode pipeline register.
// The PC takes a redirect target from execute, holds under a load-use
// stall, and otherwise steps by one word.
`timescale 1ns/1ps

module fetch_unit import proc_pkg::*; (
    input  logic  clock_i,
    input  logic  rst_n_i,
    input  logic  stall_i,
    input  logic  redirect_i,
    input  word_t redirect_pc_i,
    input  word_t imem_data_i,
    output word_t imem_addr_o,
    output word_t fd_pc_o,
    output word_t fd_ir_o
);

    word_t pc_q;

    assign imem_addr_o = pc_q;  // Instruction memory answers in the same cycle

    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            pc_q <= '0;
        end else if (redirect_i) begin
            pc_q <= redirect_pc_i;
        end else if (!stall_i) begin
            pc_q <= pc_q + 1'b1;
        end
    end

    // All-zero word is add r0,r0,r0 and serves as the bubble
    always_ff @(posedge clock_i) begin
        if (!rst_n_i || redirect_i) begin
            fd_ir_o <= '0;      // Kill the wrong-path fetch
        end else if (!stall_i) begin
            fd_ir_o <= imem_data_i;
        end
    end

    always_ff @(posedge clock_i) begin
        if (!stall_i) begin
            fd_pc_o <= pc_q;
        end
    end

endmodule

/* decode_unit.sv */
// Decode stage
// Splits the instruction into fields, decides register use and write
// enable, detects a load-use hazard against the instruction in execute,
// and loads the decode/execute pipeline register.
`timescale 1ns/1ps
`include "proc_defines.svh"

module decode_unit import proc_pkg::*; (
    input  logic     clock_i,
    input  logic     rst_n_i,
    input  logic     redirect_i,
    input  word_t    fd_pc_i,
    input  word_t    fd_ir_i,
    input  word_t    rs_data_i,
    input  word_t    rt_data_i,
    output reg_idx_t rs_idx_o,
    output reg_idx_t rt_idx_o,
    output logic     stall_o,
    output word_t    dx_pc_o,
    output opcode_t  dx_op_o,
    output alu_op_t  dx_alu_op_o,
    output shamt_t   dx_shamt_o,
    output reg_idx_t dx_rs_o,
    output reg_idx_t dx_rt_o,
    output reg_idx_t dx_rd_o,
    output word_t    dx_a_o,
    output word_t    dx_b_o,
    output word_t    dx_imm_o,
    output logic     dx_wr_en_o
);

    opcode_t  d_op;
    reg_idx_t d_rd;
    reg_idx_t d_rs;
    reg_idx_t d_b_idx;
    reg_idx_t d_dest;
    logic     d_is_jump;
    logic     d_uses_rs;
    logic     d_uses_b;
    logic     d_writes;
    logic     d_wr_en;
    word_t    d_imm;

    assign d_op = fd_ir_i[`PROC_OP_F];
    assign d_rd = fd_ir_i[`PROC_RD_F];
    assign d_rs = fd_ir_i[`PROC_RS_F];

    // Second read port reads rd except for R-type
    assign d_b_idx  = (d_op == `PROC_OP_RTYPE) ? fd_ir_i[`PROC_RT_F] : d_rd;
    assign rs_idx_o = d_rs;
    assign rt_idx_o = d_b_idx;

    assign d_is_jump = (d_op == `PROC_OP_J) || (d_op == `PROC_OP_JAL);
    assign d_uses_rs = (d_op == `PROC_OP_RTYPE) || (d_op == `PROC_OP_ADDI) ||
                       (d_op == `PROC_OP_LW) || (d_op == `PROC_OP_SW) ||
                       (d_op == `PROC_OP_BNE) || (d_op == `PROC_OP_BLT);
    // Store data is not listed, it is forwarded in the memory stage
    assign d_uses_b  = (d_op == `PROC_OP_RTYPE) || (d_op == `PROC_OP_BNE) ||
                       (d_op == `PROC_OP_BLT) || (d_op == `PROC_OP_JR);
    assign d_writes  = (d_op == `PROC_OP_RTYPE) || (d_op == `PROC_OP_ADDI) ||
                       (d_op == `PROC_OP_LW) || (d_op == `PROC_OP_JAL);

    assign d_dest  = (d_op == `PROC_OP_JAL) ? reg_idx_t'(`PROC_RA) : d_rd;
    assign d_wr_en = d_writes && (d_dest != '0);    // r0 never written

    // Jumps carry the zero-extended target in the immediate slot
    assign d_imm = d_is_jump ?
                   {{(`PROC_XLEN-`PROC_TGT_W){1'b0}}, fd_ir_i[`PROC_TGT_F]} :
                   {{(`PROC_XLEN-`PROC_IMM_W){fd_ir_i[`PROC_IMM_W-1]}},
                    fd_ir_i[`PROC_IMM_F]};

    assign stall_o = (dx_op_o == `PROC_OP_LW) && dx_wr_en_o &&
                     ((d_uses_rs && (d_rs == dx_rd_o)) ||
                      (d_uses_b && (d_b_idx == dx_rd_o)));

    always_ff @(posedge clock_i) begin
        if (!rst_n_i || stall_o || redirect_i) begin
            dx_op_o    <= `PROC_OP_RTYPE;   // Bubble
            dx_rd_o    <= '0;
            dx_wr_en_o <= 1'b0;
        end else begin
            dx_op_o    <= d_op;
            dx_rd_o    <= d_dest;
            dx_wr_en_o <= d_wr_en;
        end
    end

    always_ff @(posedge clock_i) begin
        dx_pc_o     <= fd_pc_i;
        dx_alu_op_o <= fd_ir_i[`PROC_ALU_F];
        dx_shamt_o  <= fd_ir_i[`PROC_SHAMT_F];
        dx_rs_o     <= d_rs;
        dx_rt_o     <= d_b_idx;
        dx_a_o      <= rs_data_i;
        dx_b_o      <= rt_data_i;
        dx_imm_o    <= d_imm;
    end

endmodule

/* reg_file.sv */
// General purpose register file
// 32 entries with two combinational read ports and one write port.
// A read of the entry being written returns the new data, and r0
// always reads as zero.
`timescale 1ns/1ps
`include "proc_defines.svh"

module reg_file import proc_pkg::*; (
    input  logic     clock_i,
    input  logic     rst_n_i,
    input  logic     wr_en_i,
    input  reg_idx_t wr_idx_i,
    input  reg_idx_t rd_a_idx_i,
    input  reg_idx_t rd_b_idx_i,
    input  word_t    wr_data_i,
    output word_t    rd_a_o,
    output word_t    rd_b_o
);

    word_t regs [`PROC_REGS];   // Entry 0 is never written

    function automatic word_t read_port(input reg_idx_t idx);
        word_t val;
        if (idx == '0) begin
            val = '0;
        end else if (wr_en_i && (idx == wr_idx_i)) begin
            val = wr_data_i;    // Write-through
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_comb rd_a_o = read_port(rd_a_idx_i);
    always_comb rd_b_o = read_port(rd_b_idx_i);

    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `PROC_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && (wr_idx_i != '0)) begin
            regs[wr_idx_i] <= wr_data_i;
        end
    end

endmodule

/* execute_unit.sv */
// Execute stage
// Forwards operands from the memory and writeback stages, runs the ALU,
// resolves branches and jumps into a fetch redirect, and loads the
// execute/memory pipeline register.
`timescale 1ns/1ps
`include "proc_defines.svh"

module execute_unit import proc_pkg::*; (
    input  logic     clock_i,
    input  logic     rst_n_i,
    input  word_t    dx_pc_i,
    input  opcode_t  dx_op_i,
    input  alu_op_t  dx_alu_op_i,
    input  shamt_t   dx_shamt_i,
    input  reg_idx_t dx_rs_i,
    input  reg_idx_t dx_rt_i,
    input  reg_idx_t dx_rd_i,
    input  word_t    dx_a_i,
    input  word_t    dx_b_i,
    input  word_t    dx_imm_i,
    input  logic     dx_wr_en_i,
    input  reg_idx_t m_rd_i,
    input  logic     m_wr_en_i,
    input  word_t    m_result_i,
    input  reg_idx_t w_rd_i,
    input  logic     w_wr_en_i,
    input  word_t    w_data_i,
    output logic     redirect_o,
    output word_t    redirect_pc_o,
    output opcode_t  xm_op_o,
    output reg_idx_t xm_rd_o,
    output reg_idx_t xm_rt_o,
    output logic     xm_wr_en_o,
    output word_t    xm_result_o,
    output word_t    xm_store_o
);

    word_t   x_a;
    word_t   x_b;
    word_t   alu_b;
    word_t   alu_result;
    word_t   pc_plus_one;
    word_t   x_result;
    alu_op_t alu_op;
    logic    use_imm;
    logic    take_branch;

    // Memory stage is younger, so it wins over writeback
    always_comb begin
        if (m_wr_en_i && (m_rd_i != '0) && (m_rd_i == dx_rs_i)) begin
            x_a = m_result_i;
        end else if (w_wr_en_i && (w_rd_i != '0) && (w_rd_i == dx_rs_i)) begin
            x_a = w_data_i;
        end else begin
            x_a = dx_a_i;
        end
    end

    always_comb begin
        if (m_wr_en_i && (m_rd_i != '0) && (m_rd_i == dx_rt_i)) begin
            x_b = m_result_i;
        end else if (w_wr_en_i && (w_rd_i != '0) && (w_rd_i == dx_rt_i)) begin
            x_b = w_data_i;
        end else begin
            x_b = dx_b_i;
        end
    end

    assign use_imm = (dx_op_i == `PROC_OP_ADDI) || (dx_op_i == `PROC_OP_LW) ||
                     (dx_op_i == `PROC_OP_SW);
    assign alu_b   = use_imm ? dx_imm_i : x_b;
    assign alu_op  = (dx_op_i == `PROC_OP_RTYPE) ? dx_alu_op_i : `PROC_ALU_ADD;

    always_comb begin
        case (alu_op)
            `PROC_ALU_ADD: alu_result = x_a + alu_b;
            `PROC_ALU_SUB: alu_result = x_a - alu_b;
            `PROC_ALU_AND: alu_result = x_a & alu_b;
            `PROC_ALU_OR:  alu_result = x_a | alu_b;
            `PROC_ALU_SLL: alu_result = x_a << dx_shamt_i;
            `PROC_ALU_SRA: alu_result = word_t'($signed(x_a) >>> dx_shamt_i);
            default:       alu_result = '0;
        endcase
    end

    // Branches compare rd (operand b) against rs (operand a)
    assign take_branch = ((dx_op_i == `PROC_OP_BNE) && (x_b != x_a)) ||
                         ((dx_op_i == `PROC_OP_BLT) && ($signed(x_b) < $signed(x_a)));

    assign pc_plus_one = dx_pc_i + 1'b1;

    assign redirect_o = take_branch || (dx_op_i == `PROC_OP_J) ||
                        (dx_op_i == `PROC_OP_JAL) || (dx_op_i == `PROC_OP_JR);

    always_comb begin
        if (take_branch) begin
            redirect_pc_o = pc_plus_one + dx_imm_i;
        end else if (dx_op_i == `PROC_OP_JR) begin
            redirect_pc_o = x_b;                // Forwarded rd
        end else begin
            redirect_pc_o = dx_imm_i;           // Zero-extended target
        end
    end

    assign x_result = (dx_op_i == `PROC_OP_JAL) ? pc_plus_one : alu_result;

    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            xm_op_o    <= `PROC_OP_RTYPE;
            xm_wr_en_o <= 1'b0;
        end else begin
            xm_op_o    <= dx_op_i;
            xm_wr_en_o <= dx_wr_en_i;
        end
    end

    always_ff @(posedge clock_i) begin
        xm_rd_o     <= dx_rd_i;
        xm_rt_o     <= dx_rt_i;   // Store data register
        xm_result_o <= x_result;
        xm_store_o  <= x_b;
    end

endmodule

/* mem_wb_unit.sv */
// Memory and writeback stages
// Drives the data memory from the execute/memory register, replaces
// store data with the writeback value when it is newer, and holds the
// memory/writeback register that feeds the register file.
`timescale 1ns/1ps
`include "proc_defines.svh"

module mem_wb_unit import proc_pkg::*; (
    input  logic     clock_i,
    input  logic     rst_n_i,
    input  opcode_t  xm_op_i,
    input  reg_idx_t xm_rd_i,
    input  reg_idx_t xm_rt_i,
    input  logic     xm_wr_en_i,
    input  word_t    xm_result_i,
    input  word_t    xm_store_i,
    input  word_t    dmem_rdata_i,
    output word_t    dmem_addr_o,
    output word_t    dmem_wdata_o,
    output logic     dmem_wren_o,
    output reg_idx_t m_rd_o,
    output logic     m_wr_en_o,
    output word_t    m_result_o,
    output reg_idx_t w_rd_o,
    output logic     w_wr_en_o,
    output word_t    w_data_o
);

    logic  wm_fwd;
    word_t m_data;

    assign dmem_addr_o = xm_result_i;
    assign dmem_wren_o = (xm_op_i == `PROC_OP_SW);

    // Covers a lw directly ahead of the sw that stores its result
    assign wm_fwd       = w_wr_en_o && (w_rd_o != '0) && (w_rd_o == xm_rt_i);
    assign dmem_wdata_o = wm_fwd ? w_data_o : xm_store_i;

    assign m_rd_o     = xm_rd_i;
    assign m_wr_en_o  = xm_wr_en_i;
    assign m_result_o = xm_result_i;    // Load users stall until writeback

    assign m_data = (xm_op_i == `PROC_OP_LW) ? dmem_rdata_i : xm_result_i;

    always_ff @(posedge clock_i) begin
        if (!rst_n_i) begin
            w_wr_en_o <= 1'b0;
        end else begin
            w_wr_en_o <= xm_wr_en_i;
        end
    end

    always_ff @(posedge clock_i) begin
        w_rd_o   <= xm_rd_i;
        w_data_o <= m_data;
    end

endmodule

/* proc_core.sv */
// Five-stage pipelined processor core
// Connects fetch, decode, execute and memory/writeback with the register
// file. Instruction and data memories sit outside and answer in the
// same cycle; register writes are visible on the wb ports.
`timescale 1ns/1ps

module proc_core import proc_pkg::*; (
    input  logic     clock_i,
    input  logic     rst_n_i,
    output word_t    imem_addr_o,
    input  word_t    imem_data_i,
    output word_t    dmem_addr_o,
    output word_t    dmem_wdata_o,
    output logic     dmem_wren_o,
    input  word_t    dmem_rdata_i,
    output logic     wb_en_o,
    output reg_idx_t wb_reg_o,
    output word_t    wb_data_o
);

    logic     stall;
    logic     redirect;
    word_t    redirect_pc;
    word_t    fd_pc;
    word_t    fd_ir;
    reg_idx_t rs_idx;
    reg_idx_t rt_idx;
    word_t    rs_data;
    word_t    rt_data;
    word_t    dx_pc;
    opcode_t  dx_op;
    alu_op_t  dx_alu_op;
    shamt_t   dx_shamt;
    reg_idx_t dx_rs;
    reg_idx_t dx_rt;
    reg_idx_t dx_rd;
    word_t    dx_a;
    word_t    dx_b;
    word_t    dx_imm;
    logic     dx_wr_en;
    opcode_t  xm_op;
    reg_idx_t xm_rd;
    reg_idx_t xm_rt;
    logic     xm_wr_en;
    word_t    xm_result;
    word_t    xm_store;
    reg_idx_t m_rd;
    logic     m_wr_en;
    word_t    m_result;

    fetch_unit i_fetch_unit (
        .clock_i, .rst_n_i,
        .stall_i       (stall),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .imem_data_i,
        .imem_addr_o,
        .fd_pc_o       (fd_pc),
        .fd_ir_o       (fd_ir)
    );

    decode_unit i_decode_unit (
        .clock_i, .rst_n_i,
        .redirect_i  (redirect),
        .fd_pc_i     (fd_pc),
        .fd_ir_i     (fd_ir),
        .rs_data_i   (rs_data),
        .rt_data_i   (rt_data),
        .rs_idx_o    (rs_idx),
        .rt_idx_o    (rt_idx),
        .stall_o     (stall),
        .dx_pc_o     (dx_pc),
        .dx_op_o     (dx_op),
        .dx_alu_op_o (dx_alu_op),
        .dx_shamt_o  (dx_shamt),
        .dx_rs_o     (dx_rs),
        .dx_rt_o     (dx_rt),
        .dx_rd_o     (dx_rd),
        .dx_a_o      (dx_a),
        .dx_b_o      (dx_b),
        .dx_imm_o    (dx_imm),
        .dx_wr_en_o  (dx_wr_en)
    );

    reg_file i_reg_file (
        .clock_i, .rst_n_i,
        .wr_en_i    (wb_en_o),
        .wr_idx_i   (wb_reg_o),
        .rd_a_idx_i (rs_idx),
        .rd_b_idx_i (rt_idx),
        .wr_data_i  (wb_data_o),
        .rd_a_o     (rs_data),
        .rd_b_o     (rt_data)
    );

    execute_unit i_execute_unit (
        .clock_i, .rst_n_i,
        .dx_pc_i       (dx_pc),
        .dx_op_i       (dx_op),
        .dx_alu_op_i   (dx_alu_op),
        .dx_shamt_i    (dx_shamt),
        .dx_rs_i       (dx_rs),
        .dx_rt_i       (dx_rt),
        .dx_rd_i       (dx_rd),
        .dx_a_i        (dx_a),
        .dx_b_i        (dx_b),
        .dx_imm_i      (dx_imm),
        .dx_wr_en_i    (dx_wr_en),
        .m_rd_i        (m_rd),
        .m_wr_en_i     (m_wr_en),
        .m_result_i    (m_result),
        .w_rd_i        (wb_reg_o),
        .w_wr_en_i     (wb_en_o),
        .w_data_i      (wb_data_o),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc),
        .xm_op_o       (xm_op),
        .xm_rd_o       (xm_rd),
        .xm_rt_o       (xm_rt),
        .xm_wr_en_o    (xm_wr_en),
        .xm_result_o   (xm_result),
        .xm_store_o    (xm_store)
    );

    mem_wb_unit i_mem_wb_unit (
        .clock_i, .rst_n_i,
        .xm_op_i      (xm_op),
        .xm_rd_i      (xm_rd),
        .xm_rt_i      (xm_rt),
        .xm_wr_en_i   (xm_wr_en),
        .xm_result_i  (xm_result),
        .xm_store_i   (xm_store),
        .dmem_rdata_i,
        .dmem_addr_o,
        .dmem_wdata_o,
        .dmem_wren_o,
        .m_rd_o       (m_rd),
        .m_wr_en_o    (m_wr_en),
        .m_result_o   (m_result),
        .w_rd_o       (wb_reg_o),
        .w_wr_en_o    (wb_en_o),
        .w_data_o     (wb_data_o)
    );

endmodule

/* tb_proc_core.sv */
// Testbench for the five-stage processor core
// Models instruction and data memory, builds small programs, runs a
// sequential reference model on each and checks every register write
// and every store of the core against it in order
`timescale 1ns/1ps
`include "proc_defines.svh"

module tb_proc_core import proc_pkg::*; ();

    logic     clock_i;
    logic     rst_n_i;
    word_t    imem_addr_o;
    word_t    imem_data_i;
    word_t    dmem_addr_o;
    word_t    dmem_wdata_o;
    logic     dmem_wren_o;
    word_t    dmem_rdata_i;
    logic     wb_en_o;
    reg_idx_t wb_reg_o;
    word_t    wb_data_o;

    word_t    imem [256];
    word_t    dmem [256];
    word_t    prog [$];
    reg_idx_t exp_wr_idx [$];   // Expected register writes in order
    word_t    exp_wr_val [$];
    word_t    exp_st_addr [$];  // Expected stores in order
    word_t    exp_st_val [$];
    integer   seed;
    int       errors;

    proc_core i_proc_core (
        .clock_i, .rst_n_i,
        .imem_addr_o, .imem_data_i,
        .dmem_addr_o, .dmem_wdata_o, .dmem_wren_o, .dmem_rdata_i,
        .wb_en_o, .wb_reg_o, .wb_data_o
    );

    always #50 clock_i = ~clock_i;

    assign imem_data_i  = imem[imem_addr_o[7:0]];   // Both memories answer at once
    assign dmem_rdata_i = dmem[dmem_addr_o[7:0]];

    function automatic word_t fill_word(input word_t a);
        return (a * 32'h9e3779b9) ^ 32'h00005a5a;
    endfunction

    // Data memory is restored to its fill pattern on every reset
    always @(posedge clock_i) begin
        if (!rst_n_i) begin
            for (int a = 0; a < 256; a++) begin
                dmem[a] <= fill_word(word_t'(a));
            end
        end else if (dmem_wren_o === 1'b1) begin
            dmem[dmem_addr_o[7:0]] <= dmem_wdata_o;
        end
    end

    function automatic word_t rtype_word(input alu_op_t alu, input reg_idx_t rd,
                                         input reg_idx_t rs, input reg_idx_t rt,
                                         input shamt_t sh);
        word_t w;
        w = '0;
        w[`PROC_OP_F]    = `PROC_OP_RTYPE;
        w[`PROC_RD_F]    = rd;
        w[`PROC_RS_F]    = rs;
        w[`PROC_RT_F]    = rt;
        w[`PROC_SHAMT_F] = sh;
        w[`PROC_ALU_F]   = alu;
        return w;
    endfunction

    function automatic word_t itype_word(input opcode_t op, input reg_idx_t rd,
                                         input reg_idx_t rs, input word_t imm);
        word_t w;
        w = '0;
        w[`PROC_OP_F]  = op;
        w[`PROC_RD_F]  = rd;
        w[`PROC_RS_F]  = rs;
        w[`PROC_IMM_F] = imm[16:0];
        return w;
    endfunction

    function automatic word_t jtype_word(input opcode_t op, input word_t tgt);
        word_t w;
        w = '0;
        w[`PROC_OP_F]  = op;
        w[`PROC_TGT_F] = tgt[26:0];
        return w;
    endfunction

    function automatic word_t alu_model(input alu_op_t alu, input word_t a,
                                        input word_t b, input shamt_t sh);
        case (alu)
            `PROC_ALU_ADD: return a + b;
            `PROC_ALU_SUB: return a - b;
            `PROC_ALU_AND: return a & b;
            `PROC_ALU_OR:  return a | b;
            `PROC_ALU_SLL: return a << sh;
            `PROC_ALU_SRA: return word_t'($signed(a) >>> sh);
            default:       return '0;
        endcase
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("ERROR %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic tick();
        @(posedge clock_i);
        #1;
    endtask

    task automatic check_quiet(input word_t pc_exp);
        check_value("wb_en_o", word_t'(wb_en_o), 32'd0);
        check_value("dmem_wren_o", word_t'(dmem_wren_o), 32'd0);
        check_value("imem_addr_o", imem_addr_o, pc_exp);
    endtask

    // Writes and stores are compared mid-cycle against the head of the lists
    always @(negedge clock_i) begin
        if (rst_n_i === 1'b1 && wb_en_o === 1'b1) begin
            assert (exp_wr_idx.size() > 0) else begin
                $display("Register write to r%0d when no more writes were expected", wb_reg_o);
                errors++;
            end
            if (exp_wr_idx.size() > 0) begin
                check_value("wb_reg_o", word_t'(wb_reg_o), word_t'(exp_wr_idx.pop_front()));
                check_value("wb_data_o", wb_data_o, exp_wr_val.pop_front());
            end
        end
        if (rst_n_i === 1'b1 && dmem_wren_o === 1'b1) begin
            assert (exp_st_addr.size() > 0) else begin
                $display("Store to address %h when no more stores were expected", dmem_addr_o);
                errors++;
            end
            if (exp_st_addr.size() > 0) begin
                check_value("dmem_addr_o", dmem_addr_o, exp_st_addr.pop_front());
                check_value("dmem_wdata_o", dmem_wdata_o, exp_st_val.pop_front());
            end
        end
    end

    // Sequential execution of the loaded program one instruction at a time
    task automatic run_model();
        word_t    regs_m [32];
        word_t    mem_m [256];
        word_t    pc;
        word_t    next_pc;
        word_t    ir;
        word_t    a;
        word_t    b;
        word_t    imm;
        word_t    addr;
        word_t    target;
        word_t    val;
        reg_idx_t dest;
        logic     wr;
        logic     done;
        int       steps;
        for (int i = 0; i < 32; i++) begin
            regs_m[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            mem_m[i] = fill_word(word_t'(i));
        end
        pc    = '0;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < 1000) begin
            ir      = imem[pc[7:0]];
            dest    = ir[`PROC_RD_F];
            a       = regs_m[ir[`PROC_RS_F]];
            b       = regs_m[ir[`PROC_RD_F]];   // rd is a source for non R-type
            imm     = {{15{ir[16]}}, ir[`PROC_IMM_F]};
            addr    = a + imm;
            target  = {5'd0, ir[`PROC_TGT_F]};
            next_pc = pc + 32'd1;
            wr      = 1'b0;
            val     = '0;
            case (ir[`PROC_OP_F])
                `PROC_OP_RTYPE: begin
                    wr  = 1'b1;
                    val = alu_model(ir[`PROC_ALU_F], a, regs_m[ir[`PROC_RT_F]],
                                    ir[`PROC_SHAMT_F]);
                end
                `PROC_OP_ADDI: begin
                    wr  = 1'b1;
                    val = addr;
                end
                `PROC_OP_LW: begin
                    wr  = 1'b1;
                    val = mem_m[addr[7:0]];
                end
                `PROC_OP_SW: begin
                    mem_m[addr[7:0]] = b;
                    exp_st_addr.push_back(addr);
                    exp_st_val.push_back(b);
                end
                `PROC_OP_BNE: if (b != a) next_pc = pc + 32'd1 + imm;
                `PROC_OP_BLT: if ($signed(b) < $signed(a)) next_pc = pc + 32'd1 + imm;
                `PROC_OP_J: begin
                    done    = (target == pc);
                    next_pc = target;
                end
                `PROC_OP_JAL: begin
                    wr      = 1'b1;
                    dest    = reg_idx_t'(`PROC_RA);
                    val     = pc + 32'd1;
                    next_pc = target;
                end
                `PROC_OP_JR: next_pc = b;
                default: ;
            endcase
            if (wr && dest != '0) begin   // r0 stays zero
                regs_m[dest] = val;
                exp_wr_idx.push_back(dest);
                exp_wr_val.push_back(val);
            end
            pc = next_pc;
            steps++;
        end
        if (!done) begin
            $display("Reference model never reached the closing self-jump");
            errors++;
        end
    endtask

    task automatic push_self_jump();
        prog.push_back(jtype_word(`PROC_OP_J, word_t'(prog.size())));
    endtask

    task automatic build_alu_program();
        word_t r1;
        word_t r2;
        word_t r3;
        word_t r4;
        r1 = $random(seed);
        r2 = $random(seed);
        r3 = $random(seed);
        r4 = $random(seed);
        prog.delete();
        prog.push_back(itype_word(`PROC_OP_ADDI, 5'd1, 5'd0, r1));
        prog.push_back(itype_word(`PROC_OP_ADDI, 5'd2, 5'd0, r2));
        prog.push_back(rtype_word(`PROC_ALU_ADD, 5'd3, 5'd1, 5'd2, 5'd0));
        prog.push_back(rtype_word(`PROC_ALU_SUB, 5'd4, 5'd3, 5'd1, 5'd0));
        prog.push_back(rtype_word(`PROC_ALU_AND, 5'd5, 5'd4, 5'd3, 5'd0));
        prog.push_back(rtype_word(`PROC_ALU_OR, 5'd6, 5'd5, 5'd2, 5'd0));
        prog.push_back(rtype_word(`PROC_ALU_SLL, 5'd7, 5'd6, 5'd0, r3[4:0]));
        prog.push_back(rtype_word(`PROC_ALU_SRA, 5'd8, 5'd7, 5'd0, r4[4:0]));
        prog.push_back(rtype_word(`PROC_ALU_ADD, 5'd9, 5'd8, 5'd6, 5'd0));  // r6 via write-through
        prog.push_back(itype_word(`PROC_OP_ADDI, 5'd0, 5'd1, r3));          // Dropped r0 write
        push_self_jump();
    endtask

    task automatic build_memory_program();
        word_t v1;
        word_t v2;
        word_t a1;
        word_t a2;
        word_t a3;
        word_t a4;
        v1 = $random(seed);
        v2 = $random(seed);
        a1 = 32'd16 + (word_t'($random(seed)) & 32'hf);
        a2 = 32'd48 + (word_t'($random(seed)) & 32'hf);
        a3 = 32'd80 + (word_t'($random(seed)) & 32'hf);
        a4 = 32'd112 + (word_t'($random(seed)) & 32'hf);
        prog.delete();
        prog.push_back(itype_word(`PROC_OP_ADDI, 5'd1, 5'd0, v1));
        prog.push_back(itype_word(`PROC_OP_SW, 5'd1, 5'd0, a1));
        prog.push_back(itype_word(`PROC_OP_LW, 5'd2, 5'd0, a1));
        prog.push_back(rtype_word(`PROC_ALU_ADD, 5'd3, 5'd2, 5'd1, 5'd0));  // Load-use
        prog.push_back(itype_word(`PROC_OP_SW, 5'd3, 5'd0, a2));
        prog.push_back(itype_word(`PROC_OP_LW, 5'd4, 5'd0, a2));
        prog.push_back(itype_word(`PROC_OP_SW, 5'd4, 5'd0, a3));            // Store data from lw
        prog.push_back(itype_word(`PROC_OP_LW, 5'd5, 5'd0, a3));
        prog.push_back(itype_word(`PROC_OP_ADDI, 5'd6, 5'd5, v2));
        prog.push_back(itype_word(`PROC_OP_LW, 5'd7, 5'd0, a4));
        prog.push_back(rtype_word(`PROC_ALU_SUB, 5'd8, 5'd7, 5'd6, 5'd0));
        push_self_jump();
    endtask

    task automatic build_branch_program();
        word_t v1;
        word_t v2;
        v1 = $random(seed);
        v2 = $random(seed);
        prog.delete();
        prog.push_back(itype_word(`PROC_OP_ADDI, 5'd1, 5'd0, v1));
        prog.push_back(itype_word(`PROC_OP_ADDI, 5'd2, 5'd0, v2));
        prog.push_back(itype_word(`PROC_OP_BNE, 5'd1, 5'd2, 32'd2));
        prog.push_back(itype_word(`PROC_OP_ADDI, 5'd3, 5'd0, 32'd1));
        prog.push_back(itype_word(`PROC_OP_ADDI, 5'd4, 5'd0, 32'd2));
        prog.push_back(itype_word(`PROC_OP_BNE, 5'd1, 5'd1, 32'd2));        // Never taken
        prog.push_back(itype_word(`PROC_OP_ADDI, 5'd5, 5'd0, 32'd3));
        prog.push_back(itype_word(`PROC_OP_BLT, 5'd1, 5'd2, 32'd2));
        prog.push_back(itype_word(`PROC_OP_ADDI, 5'd6, 5'd0, 32'd4));
        prog.push_back(itype_word(`PROC_OP_ADDI, 5'd7, 5'd0, 32'd5));
        prog.push_back(itype_word(`PROC_OP_BLT, 5'd2, 5'd1, 32'd2));        // Opposite sense
        prog.push_back(itype_word(`PROC_OP_ADDI, 5'd8, 5'd0, 32'd6));
        prog.push_back(itype_word(`PROC_OP_ADDI, 5'd9, 5'd0, 32'd7));
        prog.push_back(rtype_word(`PROC_ALU_ADD, 5'd10, 5'd1, 5'd2, 5'd0));
        push_self_jump();
    endtask

    task automatic build_jump_program();
        word_t v1;
        v1 = $random(seed);
        prog.delete();
        prog.push_back(itype_word(`PROC_OP_ADDI, 5'd1, 5'd0, v1));
        prog.push_back(jtype_word(`PROC_OP_JAL, 32'd6));
        prog.push_back(itype_word(`PROC_OP_ADDI, 5'd2, 5'd1, 32'd1));       // Return point
        prog.push_back(jtype_word(`PROC_OP_J, 32'd9));
        prog.push_back(itype_word(`PROC_OP_ADDI, 5'd3, 5'd0, 32'd1));
        prog.push_back(itype_word(`PROC_OP_ADDI, 5'd4, 5'd0, 32'd2));
        prog.push_back(itype_word(`PROC_OP_JR, 5'd31, 5'd0, 32'd0));        // r31 from writeback
        prog.push_back(itype_word(`PROC_OP_ADDI, 5'd5, 5'd0, 32'd3));
        prog.push_back(itype_word(`PROC_OP_ADDI, 5'd6, 5'd0, 32'd4));
        prog.push_back(rtype_word(`PROC_ALU_ADD, 5'd7, 5'd31, 5'd1, 5'd0));
        push_self_jump();
    endtask

    task automatic run_program(input string name);
        int cycles;
        rst_n_i = 1'b0;
        for (int i = 0; i < 8; i++) begin
            tick();
            check_quiet(32'd0);
        end
        for (int a = 0; a < 256; a++) begin
            imem[a] = (a < prog.size()) ? prog[a] : jtype_word(`PROC_OP_J, word_t'(a));
        end
        run_model();
        rst_n_i = 1'b1;
        tick();
        check_quiet(32'd1);                             // Only bubbles behind the first fetch
        cycles = 0;
        while ((exp_wr_idx.size() > 0 || exp_st_addr.size() > 0) && cycles < 400) begin
            tick();
            cycles++;
        end
        if (exp_wr_idx.size() > 0 || exp_st_addr.size() > 0) begin
            $display("Timeout in %s program, %0d writes and %0d stores never seen",
                     name, exp_wr_idx.size(), exp_st_addr.size());
            errors++;
            exp_wr_idx.delete();
            exp_wr_val.delete();
            exp_st_addr.delete();
            exp_st_val.delete();
        end
        for (int i = 0; i < 20; i++) begin
            tick();                                     // Extra writes show up here
        end
    endtask

    initial begin
        clock_i = 1'b0;
        rst_n_i = 1'b0;
        seed    = 32'h32bc;
        errors  = 0;
        for (int a = 0; a < 256; a++) begin
            imem[a] = jtype_word(`PROC_OP_J, word_t'(a));
        end
        build_alu_program();
        run_program("ALU chain");
        build_memory_program();
        run_program("memory");
        build_branch_program();
        run_program("branch");
        build_jump_program();
        run_program("jump");
        $display("All programs run, %0d errors", errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+.
proc_pkg.sv
fetch_unit.sv
decode_unit.sv
reg_file.sv
execute_unit.sv
mem_wb_unit.sv
proc_core.sv
tb_proc_core.sv

/* run.sh */
#!/bin/sh
# Build and run the processor core testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module tb_proc_core -o sim_proc_core
out=$(./obj_dir/sim_proc_core)
echo "$out"
echo "$out" | grep -qx "TB PASSED"
